// ==== hw/snd_pkg.sv ====
// Shared bus widths and packed structs of the sound board, referenced by scoped names
`default_nettype none

package snd_pkg;

    // Shared ROM port, CPU code and PCM samples
    localparam int ROM_AW = 19;

    // PCM sample address inside the upper ROM half
    localparam int PCM_AW = 18;

    // Default work RAM depth, 8 KiB
    localparam int RAM_AW = 13;

    // Sound CPU bus as seen at the board
    typedef struct packed {
        logic [20:0] addr;
        logic        wrn;
        logic [7:0]  cpu_dout;
    } cpu_bus_t;

    // One-hot chip selects, latched on sx
    typedef struct packed {
        logic rom;
        logic ram;
        logic pcm;
        logic latch;
    } region_t;

    // Request towards the ROM arbiter
    // Held until the matching ok pulse
    typedef struct packed {
        logic [ROM_AW-1:0] addr;
        logic              req;
    } rom_req_t;

endpackage

`default_nettype wire

// ==== hw/snd_ram.sv ====
// Single-port work RAM of the sound CPU, one cycle of read latency
`timescale 1ns/1ps
`default_nettype none

module snd_ram #(
    parameter int aw = 13
) (
    input  wire logic          clk,
    input  wire logic [aw-1:0] addr,
    input  wire logic [7:0]    data,
    input  wire logic          we,
    output      logic [7:0]    q
);

    // Byte wide storage
    logic [7:0] mem [0:(2**aw)-1];

    always_ff @(posedge clk) begin
        // Write port
        if (we) begin
            mem[addr] <= data;
        end
        // Read every cycle, old data on a write
        q <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== hw/snd_decode.sv ====
// Sound CPU bus decoder: chip selects, read mux, ROM wait and latch interrupt
`timescale 1ns/1ps
`default_nettype none

module snd_decode (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire snd_pkg::cpu_bus_t  cpu,
    input  wire logic               sx,
    input  wire logic               ce,
    input  wire logic [7:0]         latch,
    input  wire logic               snreq,
    input  wire logic [7:0]         ram_dout,
    input  wire logic [7:0]         pcm_dout,
    input  wire logic [7:0]         rom_dout,
    input  wire logic               cpu_rom_ok,
    output      snd_pkg::rom_req_t  cpu_rom,
    output      snd_pkg::region_t   sel,
    output      logic [7:0]         din,
    output      logic               waitn,
    output      logic               irqn
);

    // ROM data already received for this cycle
    logic rom_done;

    // Address is only stable between sx and ce
    // so the selects are latched on sx and dropped on ce
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= '0;
        end else if (sx) begin
            sel.rom   <= ~cpu.addr[20];
            // Region 3 holds the latch in the upper half
            sel.latch <= cpu.addr[20] && cpu.addr[19:16] == 4'd3 && cpu.addr[15];
            // and the PCM voice in the lower half
            sel.pcm   <= cpu.addr[20] && cpu.addr[19:16] == 4'd3 && !cpu.addr[15];
            // 1f0000-1f1fff
            sel.ram   <= &cpu.addr[20:16];
        end else if (ce) begin
            sel <= '0;
        end
    end

    // Marks the ok of the current ROM cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_done <= 1'b0;
        end else if (sx || ce) begin
            rom_done <= 1'b0;
        end else if (cpu_rom_ok) begin
            rom_done <= 1'b1;
        end
    end

    // Request stays up until the ok, 16-bit code space
    always_comb begin
        cpu_rom.addr = {{(snd_pkg::ROM_AW-16){1'b0}}, cpu.addr[15:0]};
        cpu_rom.req  = sel.rom & ~rom_done;
    end

    // CPU held while the fetch is pending
    // high again the cycle after the ok
    assign waitn = ~(sel.rom & ~rom_done);

    // Registered read data
    always_ff @(posedge clk) begin
        if (sel.ram) begin
            din <= ram_dout;
        end else if (sel.pcm) begin
            din <= pcm_dout;
        end else if (sel.latch) begin
            din <= latch;
        end else if (sel.rom) begin
            // ROM data only valid with its ok
            if (cpu_rom_ok) begin
                din <= rom_dout;
            end
        end else begin
            // FM regions and holes read as open bus
            din <= 8'hff;
        end
    end

    // Sound interrupt from the main CPU
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irqn <= 1'b1;
        end else if (snreq) begin
            irqn <= 1'b0;
        end else if (ce && sel.latch && cpu.wrn) begin
            // Reading the latch acknowledges it
            irqn <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/snd_pcm.sv ====
// Simple PCM voice: plays signed ROM bytes at the cen_pcm rate, scaled by fxlevel
`timescale 1ns/1ps
`default_nettype none

module snd_pcm (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire snd_pkg::cpu_bus_t  cpu,
    input  wire logic               wr,
    input  wire logic               cen_pcm,
    input  wire logic [1:0]         fxlevel,
    output      snd_pkg::rom_req_t  req,
    input  wire logic               ok,
    input  wire logic [7:0]         data,
    output      logic [7:0]         dout,
    output      logic signed [15:0] snd,
    output      logic               sample
);

    logic [snd_pkg::PCM_AW-1:0] addr;
    logic [7:0]                 count;
    logic                       busy;
    // One fetch in flight at most
    logic                       pend;
    logic signed [15:0]         ext;
    logic signed [15:0]         scaled;

    // Sign extend the ROM byte, then apply the volume step
    assign ext    = {{8{data[7]}}, data};
    assign scaled = ext <<< (5 + fxlevel);

    // Samples sit in the upper ROM half
    always_comb begin
        req.addr = {1'b1, addr};
        req.req  = pend;
    end

    // Status read, bit 0 is busy
    assign dout = {7'd0, busy};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr   <= '0;
            count  <= '0;
            busy   <= 1'b0;
            pend   <= 1'b0;
            snd    <= '0;
            sample <= 1'b0;
        end else begin
            sample <= ok;
            if (wr) begin
                // Register map on the low address bits
                case (cpu.addr[1:0])
                    2'd0: addr[7:0]   <= cpu.cpu_dout;
                    2'd1: addr[15:8]  <= cpu.cpu_dout;
                    2'd2: addr[17:16] <= cpu.cpu_dout[1:0];
                    default: begin
                        // Count write starts playback
                        count <= cpu.cpu_dout;
                        busy  <= cpu.cpu_dout != 8'd0;
                    end
                endcase
            end else if (ok) begin
                // Byte arrived, output it and advance
                pend  <= 1'b0;
                snd   <= scaled;
                addr  <= addr + 1'b1;
                count <= count - 1'b1;
                busy  <= count != 8'd1;
            end else if (cen_pcm && busy && !pend) begin
                // Next fetch on the sample tick
                // paused while the arbiter has not answered
                pend <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/snd_rom_arb.sv ====
// Shares the external ROM port between CPU code fetches and PCM sample fetches
`timescale 1ns/1ps
`default_nettype none

module snd_rom_arb (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire snd_pkg::rom_req_t          cpu_req,
    input  wire snd_pkg::rom_req_t          pcm_req,
    output      logic                       cpu_ok,
    output      logic                       pcm_ok,
    output      logic [snd_pkg::ROM_AW-1:0] rom_addr,
    output      logic                       rom_cs,
    input  wire logic                       rom_ok
);

    typedef enum logic {
        ARB_IDLE,
        ARB_GRANT
    } arb_state_t;

    arb_state_t state;
    // Owner of the grant, high for the PCM voice
    logic       owner_pcm;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ARB_IDLE;
            owner_pcm <= 1'b0;
            rom_cs    <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // CPU first, it stalls while waiting
                    if (cpu_req.req) begin
                        state     <= ARB_GRANT;
                        owner_pcm <= 1'b0;
                        rom_cs    <= 1'b1;
                    end else if (pcm_req.req) begin
                        state     <= ARB_GRANT;
                        owner_pcm <= 1'b1;
                        rom_cs    <= 1'b1;
                    end
                end
                default: begin
                    // Grant ends with the ok
                    if (rom_ok) begin
                        state  <= ARB_IDLE;
                        rom_cs <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Address captured with the grant
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE) begin
            rom_addr <= cpu_req.req ? cpu_req.addr : pcm_req.addr;
        end
    end

    // ok goes back to the owner only
    assign cpu_ok = rom_ok && state == ARB_GRANT && !owner_pcm;
    assign pcm_ok = rom_ok && state == ARB_GRANT &&  owner_pcm;

endmodule

`default_nettype wire

// ==== hw/snd_board.sv ====
// Sound board top level, bus decoder with RAM, PCM voice and ROM arbiter
`timescale 1ns/1ps
`default_nettype none

module snd_board #(
    parameter int ram_aw = snd_pkg::RAM_AW
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    // Sound CPU bus
    input  wire snd_pkg::cpu_bus_t          cpu,
    input  wire logic                       sx,
    input  wire logic                       ce,
    output      logic [7:0]                 din,
    output      logic                       waitn,
    output      logic                       irqn,
    // From main CPU
    input  wire logic                       snreq,
    input  wire logic [7:0]                 latch,
    // PCM voice
    input  wire logic                       cen_pcm,
    input  wire logic [1:0]                 fxlevel,
    // Shared ROM
    output      logic [snd_pkg::ROM_AW-1:0] rom_addr,
    output      logic                       rom_cs,
    input  wire logic [7:0]                 rom_data,
    input  wire logic                       rom_ok,
    // Sound output
    output      logic signed [15:0]         snd,
    output      logic                       sample
);

    snd_pkg::region_t  sel;
    snd_pkg::rom_req_t cpu_rom;
    snd_pkg::rom_req_t pcm_req;
    logic              cpu_rom_ok;
    logic              pcm_ok;
    logic [7:0]        ram_dout;
    logic [7:0]        pcm_dout;

    // Writes land on the ce cycle
    wire ram_we = sel.ram & ~cpu.wrn & ce;
    wire pcm_wr = sel.pcm & ~cpu.wrn & ce;

    snd_decode u_decode (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cpu        ( cpu        ),
        .sx         ( sx         ),
        .ce         ( ce         ),
        .latch      ( latch      ),
        .snreq      ( snreq      ),
        .ram_dout   ( ram_dout   ),
        .pcm_dout   ( pcm_dout   ),
        .rom_dout   ( rom_data   ),
        .cpu_rom_ok ( cpu_rom_ok ),
        .cpu_rom    ( cpu_rom    ),
        .sel        ( sel        ),
        .din        ( din        ),
        .waitn      ( waitn      ),
        .irqn       ( irqn       )
    );

    snd_ram #(.aw(ram_aw)) u_ram (
        .clk  ( clk                  ),
        .addr ( cpu.addr[ram_aw-1:0] ),
        .data ( cpu.cpu_dout         ),
        .we   ( ram_we               ),
        .q    ( ram_dout             )
    );

    snd_pcm u_pcm (
        .clk     ( clk      ),
        .rst     ( rst      ),
        .cpu     ( cpu      ),
        .wr      ( pcm_wr   ),
        .cen_pcm ( cen_pcm  ),
        .fxlevel ( fxlevel  ),
        .req     ( pcm_req  ),
        .ok      ( pcm_ok   ),
        .data    ( rom_data ),
        .dout    ( pcm_dout ),
        .snd     ( snd      ),
        .sample  ( sample   )
    );

    snd_rom_arb u_arb (
        .clk      ( clk        ),
        .rst      ( rst        ),
        .cpu_req  ( cpu_rom    ),
        .pcm_req  ( pcm_req    ),
        .cpu_ok   ( cpu_rom_ok ),
        .pcm_ok   ( pcm_ok     ),
        .rom_addr ( rom_addr   ),
        .rom_cs   ( rom_cs     ),
        .rom_ok   ( rom_ok     )
    );

endmodule

`default_nettype wire

// ==== testbench/snd_board_tb.sv ====
// Testbench for the sound board: plays the command file against the DUT as the sound CPU
`timescale 1ns/1ps
`default_nettype none

module snd_board_tb;

    // One line of the command file
    typedef struct packed {
        logic [7:0]  op;
        logic [23:0] f1;
        logic [23:0] f2;
        logic [23:0] f3;
        logic [23:0] f4;
    } cmd_t;

    logic                       clk;
    logic                       rst;
    snd_pkg::cpu_bus_t          cpu;
    logic                       sx;
    logic                       ce;
    logic [7:0]                 din;
    logic                       waitn;
    logic                       irqn;
    logic                       snreq;
    logic [7:0]                 latch;
    logic                       cen_pcm;
    logic [1:0]                 fxlevel;
    logic [snd_pkg::ROM_AW-1:0] rom_addr;
    logic                       rom_cs;
    logic [7:0]                 rom_data;
    logic                       rom_ok;
    logic signed [15:0]         snd;
    logic                       sample;

    cmd_t               cmds[$];
    // Expected and observed PCM outputs, in order
    logic signed [15:0] snd_exp[$];
    logic signed [15:0] snd_got[$];
    int                 checks = 0;
    int                 errors = 0;
    int                 limit = 0;
    bit                 loaded = 1'b0;

    snd_board DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Sample tick every 16 cycles
    initial begin
        cen_pcm = 1'b0;
        wait (rst == 1'b0);
        forever begin
            repeat (15) @(posedge clk);
            #1 cen_pcm = 1'b1;
            @(posedge clk);
            #1 cen_pcm = 1'b0;
        end
    end

    // ROM data rule, bit 18 marks the PCM half
    function automatic logic [7:0] rom_rule(input logic [18:0] a);
        return a[7:0] ^ a[15:8] ^ (a[18] ? 8'h5a : 8'h00);
    endfunction

    // Signed sample times the volume step
    function automatic logic signed [15:0] pcm_expect(input logic [17:0] a, input logic [1:0] fx);
        logic signed [7:0] b;
        int                v;
        b = rom_rule({1'b1, a});
        v = int'(b) * (1 << (5 + int'(fx)));
        return v[15:0];
    endfunction

    // ROM model, answers each grant after 1 to 4 cycles
    initial begin : rom_model
        int lat;
        rom_ok = 1'b0;
        rom_data = 8'h00;
        forever begin
            @(posedge clk);
            #1;
            if (rom_cs === 1'b1) begin
                lat = 1 + int'($urandom % 4);
                repeat (lat - 1) begin
                    @(posedge clk);
                    #1;
                end
                rom_data = rom_rule(rom_addr);
                rom_ok = 1'b1;
                @(posedge clk);
                #1 rom_ok = 1'b0;
            end
        end
    end

    // Collect every PCM output as it appears
    always @(negedge clk) begin
        if (sample === 1'b1) begin
            snd_got.push_back(snd);
        end
    end

    // Ends a run that stops making progress
    initial begin : watchdog
        wait (loaded);
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", limit);
        $display("Test failed");
        $finish;
    end

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_snd(input logic signed [15:0] got, input logic signed [15:0] exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Bus tasks start and end 1 ns after a rising edge
    task automatic bus_write(input logic [20:0] a, input logic [7:0] d);
        cpu.addr = a;
        cpu.wrn = 1'b0;
        cpu.cpu_dout = d;
        sx = 1'b1;
        @(posedge clk);
        #1 sx = 1'b0;
        ce = 1'b1;
        @(posedge clk);
        #1 ce = 1'b0;
        cpu.wrn = 1'b1;
    endtask

    // Read cycle, sw reports whether waitn was seen low
    task automatic bus_read(input logic [20:0] a, output logic [7:0] d, output logic sw);
        int n;
        cpu.addr = a;
        cpu.wrn = 1'b1;
        sx = 1'b1;
        @(posedge clk);
        #1 sx = 1'b0;
        sw = ~waitn;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            if (!waitn) begin
                sw = 1'b1;
            end
            n++;
        end while (!waitn && n < 100);
        d = din;
        if (!waitn) begin
            // No ce while the CPU is held
            errors++;
            $display("waitn stayed low for 100 cycles on the read of %06h", a);
        end else begin
            ce = 1'b1;
            @(posedge clk);
            #1 ce = 1'b0;
        end
    endtask

    task automatic latch_cycle(input logic [7:0] v);
        logic [7:0] d;
        logic       sw;
        latch = v;
        snreq = 1'b1;
        @(posedge clk);
        #1 snreq = 1'b0;
        check_level(irqn, 1'b0, "irqn after snreq");
        bus_read(21'h138000, d, sw);
        check_byte(d, v, "latch read");
        check_level(irqn, 1'b1, "irqn after latch read");
    endtask

    // Waits for the pending samples and compares them in order
    task automatic finish_play();
        int                 n;
        logic signed [15:0] e;
        logic signed [15:0] g;
        n = 0;
        while (snd_got.size() < snd_exp.size() && n < 64 + 40 * snd_exp.size()) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (snd_got.size() < snd_exp.size()) begin
            errors++;
            $display("PCM voice gave %0d of %0d samples before the timeout",
                     snd_got.size(), snd_exp.size());
        end
        while (snd_exp.size() > 0 && snd_got.size() > 0) begin
            e = snd_exp.pop_front();
            g = snd_got.pop_front();
            check_snd(g, e, "pcm sample");
        end
        if (snd_got.size() > 0) begin
            errors++;
            $display("PCM voice gave %0d more samples than requested", snd_got.size());
        end
        snd_exp.delete();
        snd_got.delete();
    endtask

    // Register writes in address order, the count starts the voice
    task automatic play(input logic [17:0] start, input logic [7:0] n, input logic [1:0] fx,
                        input logic wait_done);
        finish_play();
        fxlevel = fx;
        for (int i = 0; i < int'(n); i++) begin
            snd_exp.push_back(pcm_expect(start + 18'(i), fx));
        end
        bus_write(21'h130000, start[7:0]);
        bus_write(21'h130001, start[15:8]);
        bus_write(21'h130002, {6'd0, start[17:16]});
        bus_write(21'h130003, n);
        if (wait_done) begin
            finish_play();
        end
    endtask

    task automatic run_cmd(input int idx, input cmd_t c);
        int         err0;
        logic [7:0] d;
        logic       sw;
        string      text;
        err0 = errors;
        case (c.op)
            "w": begin
                text = $sformatf("write %06h = %02h", c.f1[20:0], c.f2[7:0]);
                bus_write(c.f1[20:0], c.f2[7:0]);
            end
            "r": begin
                text = $sformatf("read %06h", c.f1[20:0]);
                bus_read(c.f1[20:0], d, sw);
                check_byte(d, c.f2[7:0], text);
                // Only ROM reads hold the CPU
                check_level(sw, ~c.f1[20], "waitn low during read");
            end
            "l": begin
                text = $sformatf("latch %02h", c.f1[7:0]);
                latch_cycle(c.f1[7:0]);
            end
            "p": begin
                text = $sformatf("play %05h x%0d fx %0d", c.f1[17:0], c.f2[7:0], c.f3[1:0]);
                play(c.f1[17:0], c.f2[7:0], c.f3[1:0], c.f4[0]);
            end
            default: begin
                text = "unknown";
                errors++;
                $display("Unknown command %s in the input file", c.op);
            end
        endcase
        $display("step %0d %s: %s", idx, text, (errors == err0) ? "ok" : "mismatch");
    endtask

    initial begin : main
        int          fd;
        string       line;
        cmd_t        c;
        logic [23:0] f1;
        logic [23:0] f2;
        logic [23:0] f3;
        logic [23:0] f4;
        void'($urandom(32'hc2264805));
        rst = 1'b1;
        cpu = '0;
        cpu.wrn = 1'b1;
        sx = 1'b0;
        ce = 1'b0;
        snreq = 1'b0;
        latch = 8'h00;
        fxlevel = 2'd0;
        fd = $fopen("testbench/snd_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open testbench/snd_input.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Skip blank and comment lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    f1 = '0;
                    f2 = '0;
                    f3 = '0;
                    f4 = '0;
                    void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", f1, f2, f3, f4));
                    c.op = line.getc(0);
                    c.f1 = f1;
                    c.f2 = f2;
                    c.f3 = f3;
                    c.f4 = f4;
                    cmds.push_back(c);
                end
            end
            $fclose(fd);
        end
        limit = (cmds.size() + 4) * 200;
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        // State right after reset
        check_level(rom_cs, 1'b0, "rom_cs after reset");
        check_level(waitn, 1'b1, "waitn after reset");
        check_level(irqn, 1'b1, "irqn after reset");
        check_level(sample, 1'b0, "sample after reset");
        check_snd(snd, 16'sd0, "snd after reset");
        foreach (cmds[i]) begin
            run_cmd(i, cmds[i]);
        end
        // Catch a playback still open at the end
        finish_play();
        $display("%0d steps, %0d checks, %0d errors", cmds.size(), checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/snd_pkg.sv
hw/snd_ram.sv
hw/snd_decode.sv
hw/snd_pcm.sv
hw/snd_rom_arb.sv
hw/snd_board.sv
testbench/snd_board_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the sound board testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module snd_board_tb -f vlog.f -o snd_sim
status=0
./obj_dir/snd_sim > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished cleanly"

// ==== testbench/snd_input.txt ====
# op  field1  field2  field3  field4, all hex
# w addr data | r addr expected | l latch_value | p pcm_addr count fxlevel wait_done
w 1f0010 a5
w 1f1fff 3c
r 1f0010 a5
r 1f1fff 3c
w 1f0000 00
r 1f0000 00
r 001234 26
r 00abcd 66
r 0a9001 91
r 0055aa ff
l 3c
l c7
r 100000 ff
r 120004 ff
r 1e0000 ff
p 00010 08 0 1
r 130003 00
p 3fffe 04 3 1
p 00080 06 2 1
p 00200 10 2 0
r 130003 01
r 007f01 7e
r 00ffee 11
r 1f0010 a5
r 00c3c3 00
p 00300 04 1 1
r 130003 00
